//--- design/frame_tick.sv
module frame_tick #(
	parameter int FRAME_CYCLES = 833333
) (
	input  logic CLOCK_50,
	input  logic arst_n,
	output logic frame
);
	localparam int CW = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;

	logic [CW-1:0] count;

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			count <= CW'(FRAME_CYCLES - 1);
			frame <= 1'b0;
		end else begin
			frame <= (count == '0);
			if (count == '0)
				count <= CW'(FRAME_CYCLES - 1);	// Fixed period reload
			else
				count <= count - CW'(1);
		end
	end

endmodule

//--- design/game_pkg.sv
package game_pkg;

	localparam int FIELD_W = 160;
	localparam int FIELD_H = 120;

	typedef logic [7:0] coord_t;

	// Limits on the top left corner of a tank
	localparam coord_t Y_MIN    = 8'd10;
	localparam coord_t Y_MAX    = 8'd100;
	localparam coord_t P1_X_MIN = 8'd123;
	localparam coord_t P1_X_MAX = 8'd144;
	localparam coord_t P2_X_MIN = 8'd8;
	localparam coord_t P2_X_MAX = 8'd30;
	localparam coord_t HOME_Y   = 8'd50;
	localparam coord_t GUN_DY   = 8'd3;	// Gun row below tank top

	localparam coord_t P1_BULLET_END = 8'd0;
	localparam coord_t P2_BULLET_END = 8'd152;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
	} player_cmd_t;

	typedef enum logic {
		BULLET_READY,
		BULLET_FLYING
	} bullet_state_t;

	typedef struct packed {
		coord_t        tank_x;
		coord_t        tank_y;
		coord_t        bullet_x;
		coord_t        bullet_y;
		bullet_state_t bullet_state;
	} player_pos_t;

	typedef logic [3:0] score_t;	// Wraps at 16

endpackage

//--- design/pixel_pkg.sv
package pixel_pkg;
	import game_pkg::*;

	typedef enum logic [2:0] {
		COL_BLACK = 3'b000,
		COL_BLUE  = 3'b001,
		COL_CYAN  = 3'b011
	} colour_t;

	typedef struct packed {
		coord_t  x;
		coord_t  y;
		colour_t colour;
	} pixel_t;

	localparam int TANK_W   = 8;
	localparam int TANK_H   = 16;
	localparam int GUN_W    = 4;
	localparam int GUN_H    = 2;
	localparam int BULLET_W = 4;
	localparam int BULLET_H = 2;

	typedef logic [6:0] seg_t;	// Active low, bit 6 is g

	// Gun sits on the tank side that faces the opponent
	function automatic coord_t gun_x(coord_t tank_x, logic face_left);
		return face_left ? tank_x - coord_t'(GUN_W) : tank_x + coord_t'(TANK_W);
	endfunction

endpackage

//--- design/player_unit.sv
module player_unit
	import game_pkg::*;
	import pixel_pkg::*;
#(
	parameter coord_t HOME_X     = P1_X_MAX,
	parameter coord_t X_MIN      = P1_X_MIN,
	parameter coord_t X_MAX      = P1_X_MAX,
	parameter logic   FACE_LEFT  = 1'b1,
	parameter coord_t BULLET_END = P1_BULLET_END
) (
	input  logic        CLOCK_50,
	input  logic        arst_n,
	input  logic        frame,
	input  player_cmd_t cmd,
	input  logic        hit,
	output player_pos_t pos
);
	player_pos_t nxt;
	coord_t      tx;
	coord_t      ty;
	coord_t      start_x;
	coord_t      shot_x;
	logic        flying;

	always_comb begin
		tx = pos.tank_x;
		ty = pos.tank_y;
		if (cmd.up && !cmd.down && pos.tank_y > Y_MIN)
			ty = pos.tank_y - 8'd1;
		else if (cmd.down && !cmd.up && pos.tank_y < Y_MAX)
			ty = pos.tank_y + 8'd1;
		if (cmd.left && !cmd.right && pos.tank_x > X_MIN)
			tx = pos.tank_x - 8'd1;
		else if (cmd.right && !cmd.left && pos.tank_x < X_MAX)
			tx = pos.tank_x + 8'd1;

		flying = (pos.bullet_state == BULLET_FLYING);
		// A launch leaves from the moved gun and steps at once
		start_x = flying ? pos.bullet_x : gun_x(tx, FACE_LEFT);
		shot_x = FACE_LEFT ? start_x - 8'd1 : start_x + 8'd1;

		nxt.tank_x       = tx;
		nxt.tank_y       = ty;
		nxt.bullet_x     = gun_x(tx, FACE_LEFT);	// Ready bullet rides on the gun
		nxt.bullet_y     = ty + GUN_DY;
		nxt.bullet_state = BULLET_READY;
		if ((flying || cmd.fire) && shot_x != BULLET_END) begin
			nxt.bullet_x     = shot_x;
			nxt.bullet_y     = flying ? pos.bullet_y : ty + GUN_DY;
			nxt.bullet_state = BULLET_FLYING;
		end
	end

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			pos <= '{HOME_X, HOME_Y, gun_x(HOME_X, FACE_LEFT), HOME_Y + GUN_DY, BULLET_READY};
		end else if (frame) begin
			pos <= nxt;
		end else if (hit) begin
			pos.bullet_x     <= gun_x(pos.tank_x, FACE_LEFT);
			pos.bullet_y     <= pos.tank_y + GUN_DY;
			pos.bullet_state <= BULLET_READY;
		end
	end

endmodule

//--- design/score_keeper.sv
module score_keeper
	import game_pkg::*;
	import pixel_pkg::*;
(
	input  logic        CLOCK_50,
	input  logic        arst_n,
	input  logic        frame,
	input  player_pos_t p1_pos,
	input  player_pos_t p2_pos,
	output logic        hit_p1,
	output logic        hit_p2,
	output seg_t        seg_p1,
	output seg_t        seg_p2
);
	logic   judge;
	logic   p1_scores;
	logic   p2_scores;
	score_t score_p1;
	score_t score_p2;

	function automatic logic hits(player_pos_t shooter, player_pos_t target);
		return shooter.bullet_state == BULLET_FLYING
			&& shooter.bullet_x >= target.tank_x
			&& shooter.bullet_x <= target.tank_x + coord_t'(TANK_W - 1)
			&& shooter.bullet_y >= target.tank_y
			&& shooter.bullet_y <= target.tank_y + coord_t'(TANK_H - 1);
	endfunction

	function automatic seg_t hex_seg(score_t digit);
		case (digit)
			4'h0: return 7'b100_0000;
			4'h1: return 7'b111_1001;
			4'h2: return 7'b010_0100;
			4'h3: return 7'b011_0000;
			4'h4: return 7'b001_1001;
			4'h5: return 7'b001_0010;
			4'h6: return 7'b000_0010;
			4'h7: return 7'b111_1000;
			4'h8: return 7'b000_0000;
			4'h9: return 7'b001_1000;
			4'hA: return 7'b000_1000;
			4'hB: return 7'b000_0011;
			4'hC: return 7'b100_0110;
			4'hD: return 7'b010_0001;
			4'hE: return 7'b000_0110;
			default: return 7'b000_1110;
		endcase
	endfunction

	assign p1_scores = judge && hits(p1_pos, p2_pos);
	assign p2_scores = judge && hits(p2_pos, p1_pos);

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			judge    <= 1'b0;
			hit_p1   <= 1'b0;
			hit_p2   <= 1'b0;
			score_p1 <= '0;
			score_p2 <= '0;
		end else begin
			judge  <= frame;	// Positions have moved by then
			hit_p1 <= p1_scores;
			hit_p2 <= p2_scores;
			if (p1_scores)
				score_p1 <= score_p1 + 4'd1;
			if (p2_scores)
				score_p2 <= score_p2 + 4'd1;
		end
	end

	assign seg_p1 = hex_seg(score_p1);
	assign seg_p2 = hex_seg(score_p2);

endmodule

//--- design/sprite_plotter.sv
module sprite_plotter
	import game_pkg::*;
	import pixel_pkg::*;
#(
	parameter coord_t P1_HOME_X = P1_X_MAX,
	parameter coord_t P2_HOME_X = P2_X_MIN
) (
	input  logic        CLOCK_50,
	input  logic        arst_n,
	input  logic        frame,
	input  player_pos_t p1_pos,
	input  player_pos_t p2_pos,
	output pixel_t      pixel,
	output logic        plot
);
	typedef enum logic [1:0] {
		ST_CLEAR,
		ST_IDLE,
		ST_ERASE,
		ST_DRAW
	} plot_state_t;

	plot_state_t state;
	logic [2:0]  sprite;	// 0 to 2 player 1, 3 to 5 player 2
	logic [2:0]  px;
	logic [3:0]  py;
	coord_t      cx;
	coord_t      cy;
	player_pos_t snap_p1;	// What is on screen now
	player_pos_t snap_p2;

	player_pos_t src;
	logic        first_draw;
	logic        walk;
	logic        row_end;
	logic        sprite_end;
	coord_t      base_x;
	coord_t      base_y;
	logic [2:0]  w_last;
	logic [3:0]  h_last;
	colour_t     draw_colour;

	assign first_draw = (state == ST_DRAW) && sprite == 3'd0 && px == 3'd0 && py == 4'd0;
	assign walk = (state == ST_ERASE) || (state == ST_DRAW) || (state == ST_IDLE && frame);

	always_comb begin
		// First draw pixel reads the positions being latched
		if (sprite < 3'd3)
			src = first_draw ? p1_pos : snap_p1;
		else
			src = snap_p2;

		base_x = src.bullet_x;
		base_y = src.bullet_y;
		w_last = 3'(BULLET_W - 1);
		h_last = 4'(BULLET_H - 1);
		if (sprite == 3'd0 || sprite == 3'd3) begin
			base_x = src.tank_x;
			base_y = src.tank_y;
			w_last = 3'(TANK_W - 1);
			h_last = 4'(TANK_H - 1);
		end else if (sprite == 3'd1 || sprite == 3'd4) begin
			base_x = gun_x(src.tank_x, sprite == 3'd1);
			base_y = src.tank_y + GUN_DY;
			w_last = 3'(GUN_W - 1);
			h_last = 4'(GUN_H - 1);
		end

		if (state != ST_DRAW)
			draw_colour = COL_BLACK;
		else if (sprite < 3'd3)
			draw_colour = COL_CYAN;
		else
			draw_colour = COL_BLUE;
	end

	assign row_end = (px == w_last);
	assign sprite_end = row_end && (py == h_last);

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			state   <= ST_CLEAR;
			plot    <= 1'b0;
			sprite  <= '0;
			px      <= '0;
			py      <= '0;
			cx      <= '0;
			cy      <= '0;
			snap_p1 <= '{P1_HOME_X, HOME_Y, gun_x(P1_HOME_X, 1'b1), HOME_Y + GUN_DY, BULLET_READY};
			snap_p2 <= '{P2_HOME_X, HOME_Y, gun_x(P2_HOME_X, 1'b0), HOME_Y + GUN_DY, BULLET_READY};
		end else begin
			plot <= (state == ST_CLEAR) || walk;
			if (state == ST_CLEAR) begin
				if (cx == coord_t'(FIELD_W - 1)) begin
					cx <= '0;
					cy <= cy + 8'd1;
					if (cy == coord_t'(FIELD_H - 1))
						state <= ST_IDLE;
				end else begin
					cx <= cx + 8'd1;
				end
			end else if (walk) begin
				if (state == ST_IDLE)
					state <= ST_ERASE;	// Frames during a sequence are ignored
				if (first_draw) begin
					snap_p1 <= p1_pos;
					snap_p2 <= p2_pos;
				end
				if (!row_end) begin
					px <= px + 3'd1;
				end else begin
					px <= '0;
					if (!sprite_end) begin
						py <= py + 4'd1;
					end else begin
						py <= '0;
						if (sprite == 3'd5) begin
							sprite <= '0;
							state <= (state == ST_DRAW) ? ST_IDLE : ST_DRAW;
						end else begin
							sprite <= sprite + 3'd1;
						end
					end
				end
			end
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (state == ST_CLEAR)
			pixel <= '{x: cx, y: cy, colour: COL_BLACK};
		else
			pixel <= '{x: base_x + coord_t'(px), y: base_y + coord_t'(py), colour: draw_colour};
	end

endmodule

//--- design/tank_duel.sv
module tank_duel
	import game_pkg::*;
	import pixel_pkg::*;
#(
	parameter int FRAME_CYCLES = 833333
) (
	input  logic        CLOCK_50,
	input  logic        arst_n,
	input  player_cmd_t p1_cmd,
	input  player_cmd_t p2_cmd,
	output pixel_t      pixel,
	output logic        plot,
	output seg_t        seg_p1,
	output seg_t        seg_p2
);
	localparam coord_t P1_HOME_X = 8'd144;
	localparam coord_t P2_HOME_X = 8'd8;

	logic        frame;
	logic        hit_p1;
	logic        hit_p2;
	player_pos_t p1_pos;
	player_pos_t p2_pos;

	frame_tick #(
		.FRAME_CYCLES(FRAME_CYCLES)
	) i_frame_tick (
		.CLOCK_50(CLOCK_50),
		.arst_n  (arst_n),
		.frame   (frame)
	);

	// Player 1 holds the right half and shoots left
	player_unit #(
		.HOME_X    (P1_HOME_X),
		.X_MIN     (P1_X_MIN),
		.X_MAX     (P1_X_MAX),
		.FACE_LEFT (1'b1),
		.BULLET_END(P1_BULLET_END)
	) i_player_1 (
		.CLOCK_50(CLOCK_50),
		.arst_n  (arst_n),
		.frame   (frame),
		.cmd     (p1_cmd),
		.hit     (hit_p1),
		.pos     (p1_pos)
	);

	player_unit #(
		.HOME_X    (P2_HOME_X),
		.X_MIN     (P2_X_MIN),
		.X_MAX     (P2_X_MAX),
		.FACE_LEFT (1'b0),
		.BULLET_END(P2_BULLET_END)
	) i_player_2 (
		.CLOCK_50(CLOCK_50),
		.arst_n  (arst_n),
		.frame   (frame),
		.cmd     (p2_cmd),
		.hit     (hit_p2),
		.pos     (p2_pos)
	);

	score_keeper i_score_keeper (
		.CLOCK_50(CLOCK_50),
		.arst_n  (arst_n),
		.frame   (frame),
		.p1_pos  (p1_pos),
		.p2_pos  (p2_pos),
		.hit_p1  (hit_p1),
		.hit_p2  (hit_p2),
		.seg_p1  (seg_p1),
		.seg_p2  (seg_p2)
	);

	sprite_plotter #(
		.P1_HOME_X(P1_HOME_X),
		.P2_HOME_X(P2_HOME_X)
	) i_sprite_plotter (
		.CLOCK_50(CLOCK_50),
		.arst_n  (arst_n),
		.frame   (frame),
		.p1_pos  (p1_pos),
		.p2_pos  (p2_pos),
		.pixel   (pixel),
		.plot    (plot)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the tank duel testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_tank_duel \
	-Mdir obj_dir -o tb_tank_duel
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_tank_duel > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi
exit 0

//--- tb/tank_duel_properties.sv
module tank_duel_properties
	import game_pkg::*;
	import pixel_pkg::*;
(
	input logic   CLOCK_50,
	input logic   arst_n,
	input pixel_t pixel,
	input logic   plot,
	input logic   hit_p1,
	input logic   hit_p2,
	input score_t score_p1,
	input score_t score_p2
);
	timeunit 1ns;
	timeprecision 1ps;

	plot_quiet_in_reset: assert property (@(posedge CLOCK_50) !arst_n |-> !plot)
		else $error("plot high while reset is asserted");

	// Every plotted pixel lands on the playfield
	pixel_on_field: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		plot |-> (pixel.x < 8'd160 && pixel.y < 8'd120))
		else $error("plotted pixel outside the playfield");

	hit_p1_single: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		hit_p1 |=> !hit_p1)
		else $error("hit_p1 longer than one cycle");

	hit_p2_single: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		hit_p2 |=> !hit_p2)
		else $error("hit_p2 longer than one cycle");

	score_p1_step: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		(score_p1 != $past(score_p1)) |-> (score_p1 == score_t'($past(score_p1) + 4'd1)))
		else $error("score_p1 changed by more than one");

	score_p2_step: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		(score_p2 != $past(score_p2)) |-> (score_p2 == score_t'($past(score_p2) + 4'd1)))
		else $error("score_p2 changed by more than one");

endmodule

bind tank_duel tank_duel_properties i_tank_duel_properties (
	.CLOCK_50(CLOCK_50),
	.arst_n  (arst_n),
	.pixel   (pixel),
	.plot    (plot),
	.hit_p1  (hit_p1),
	.hit_p2  (hit_p2),
	.score_p1(i_score_keeper.score_p1),
	.score_p2(i_score_keeper.score_p2)
);

//--- tb/tb_tank_duel.sv
module tb_tank_duel
	import game_pkg::*;
	import pixel_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int FRAME_CYCLES = 1024;
	localparam int CLEAR_PIXELS = FIELD_W * FIELD_H;
	localparam int RUN_FRAMES = 200;	// Long enough for bullets to cross the field
	localparam int RUN_CYCLES = RUN_FRAMES * FRAME_CYCLES + 300;
	localparam int TIMEOUT_CYCLES = CLEAR_PIXELS + RUN_FRAMES * FRAME_CYCLES + 2000;
	localparam logic [31:0] SEED = 32'h85ba;

	logic        CLOCK_50;
	logic        arst_n;
	player_cmd_t p1_cmd;
	player_cmd_t p2_cmd;
	pixel_t      pixel;
	logic        plot;
	seg_t        seg_p1;
	seg_t        seg_p2;

	// Reference model state
	player_pos_t m_p1;
	player_pos_t m_p2;
	player_pos_t drawn_p1;	// Last sprites sent to the screen
	player_pos_t drawn_p2;
	score_t      m_score1;
	score_t      m_score2;
	pixel_t      exp_q[$];
	int          drift1;
	int          drift2;
	int          hits_seen;
	int          cycles = 0;

	tank_duel #(
		.FRAME_CYCLES(FRAME_CYCLES)
	) i_tank_duel (
		.CLOCK_50(CLOCK_50),
		.arst_n  (arst_n),
		.p1_cmd  (p1_cmd),
		.p2_cmd  (p2_cmd),
		.pixel   (pixel),
		.plot    (plot),
		.seg_p1  (seg_p1),
		.seg_p2  (seg_p2)
	);

	always #2 CLOCK_50 = ~CLOCK_50;

	task automatic abort_run();
		$display("Simulation FAILED");
		$fatal(1, "stopping at first error");
	endtask

	always @(posedge CLOCK_50) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	function automatic coord_t gun_col(coord_t tx, logic left);
		return left ? tx - 8'd4 : tx + 8'd8;
	endfunction

	function automatic coord_t step_in(coord_t v, logic dec, logic inc, coord_t lo, coord_t hi);
		if (dec && !inc && v > lo)
			return v - 8'd1;
		if (inc && !dec && v < hi)
			return v + 8'd1;
		return v;
	endfunction

	function automatic player_pos_t send_home(player_pos_t p, logic left);
		player_pos_t n;
		n = p;
		n.bullet_x = gun_col(p.tank_x, left);
		n.bullet_y = p.tank_y + GUN_DY;
		n.bullet_state = BULLET_READY;
		return n;
	endfunction

	function automatic player_pos_t move_player(player_pos_t p, player_cmd_t c, coord_t xlo,
			coord_t xhi, logic left, coord_t last);
		player_pos_t n;
		coord_t      bx;
		n.tank_x = step_in(p.tank_x, c.left, c.right, xlo, xhi);
		n.tank_y = step_in(p.tank_y, c.up, c.down, Y_MIN, Y_MAX);
		n = send_home(n, left);
		if (p.bullet_state == BULLET_FLYING) begin
			bx = left ? p.bullet_x - 8'd1 : p.bullet_x + 8'd1;
			if (bx != last) begin
				n.bullet_x = bx;
				n.bullet_y = p.bullet_y;
				n.bullet_state = BULLET_FLYING;
			end
		end else if (c.fire) begin
			bx = left ? n.bullet_x - 8'd1 : n.bullet_x + 8'd1;	// Launch already steps
			if (bx != last) begin
				n.bullet_x = bx;
				n.bullet_state = BULLET_FLYING;
			end
		end
		return n;
	endfunction

	function automatic logic bullet_hits(player_pos_t s, player_pos_t t);
		return s.bullet_state == BULLET_FLYING
			&& int'(s.bullet_x) >= int'(t.tank_x) && int'(s.bullet_x) <= int'(t.tank_x) + 7
			&& int'(s.bullet_y) >= int'(t.tank_y) && int'(s.bullet_y) <= int'(t.tank_y) + 15;
	endfunction

	function automatic seg_t digit_pattern(score_t d);
		case (d)
			4'h0: return 7'h40;
			4'h1: return 7'h79;
			4'h2: return 7'h24;
			4'h3: return 7'h30;
			4'h4: return 7'h19;
			4'h5: return 7'h12;
			4'h6: return 7'h02;
			4'h7: return 7'h78;
			4'h8: return 7'h00;
			4'h9: return 7'h18;
			4'hA: return 7'h08;
			4'hB: return 7'h03;
			4'hC: return 7'h46;
			4'hD: return 7'h21;
			4'hE: return 7'h06;
			default: return 7'h0E;
		endcase
	endfunction

	// Drift picks the direction held most of the time, to reach the range limits
	function automatic player_cmd_t random_cmd(int drift);
		player_cmd_t c;
		c.up    = (drift == 0) ? ($urandom % 8 != 0) : ($urandom % 8 == 0);
		c.down  = (drift == 1) ? ($urandom % 8 != 0) : ($urandom % 8 == 0);
		c.left  = (drift == 2) ? ($urandom % 8 != 0) : ($urandom % 8 == 0);
		c.right = (drift == 3) ? ($urandom % 8 != 0) : ($urandom % 8 == 0);
		c.fire  = ($urandom % 12 == 0);
		return c;
	endfunction

	task automatic push_sprite(coord_t bx, coord_t by, int w, int h, colour_t c);
		pixel_t p;
		for (int y = 0; y < h; y++) begin
			for (int x = 0; x < w; x++) begin
				p = '{x: bx + coord_t'(x), y: by + coord_t'(y), colour: c};
				exp_q.push_back(p);
			end
		end
	endtask

	task automatic push_player(player_pos_t p, logic left, colour_t c);
		push_sprite(p.tank_x, p.tank_y, 8, 16, c);
		push_sprite(gun_col(p.tank_x, left), p.tank_y + GUN_DY, 4, 2, c);
		push_sprite(p.bullet_x, p.bullet_y, 4, 2, c);
	endtask

	task automatic push_frame();
		push_player(drawn_p1, 1'b1, COL_BLACK);
		push_player(drawn_p2, 1'b0, COL_BLACK);
		push_player(m_p1, 1'b1, COL_CYAN);
		push_player(m_p2, 1'b0, COL_BLUE);
		drawn_p1 = m_p1;
		drawn_p2 = m_p2;
	endtask

	task automatic update_model();
		logic h1;
		logic h2;
		m_p1 = move_player(m_p1, p1_cmd, P1_X_MIN, P1_X_MAX, 1'b1, P1_BULLET_END);
		m_p2 = move_player(m_p2, p2_cmd, P2_X_MIN, P2_X_MAX, 1'b0, P2_BULLET_END);
		h1 = bullet_hits(m_p1, m_p2);
		h2 = bullet_hits(m_p2, m_p1);
		if (h1) begin
			m_score1 = m_score1 + 4'd1;
			m_p1 = send_home(m_p1, 1'b1);
			hits_seen++;
		end
		if (h2) begin
			m_score2 = m_score2 + 4'd1;
			m_p2 = send_home(m_p2, 1'b0);
			hits_seen++;
		end
	endtask

	task automatic drive_commands(int frame_no);
		if (frame_no % 16 == 0) begin
			drift1 = $urandom % 4;
			drift2 = $urandom % 4;
		end
		p1_cmd <= random_cmd(drift1);
		p2_cmd <= random_cmd(drift2);
	endtask

	task automatic check_pixel(pixel_t got, pixel_t exp, string name);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h expected %h (cycle %0d)", name, got, exp, cycles);
			abort_run();
		end
	endtask

	task automatic check_plot(logic got, logic exp, string name);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h expected %h (cycle %0d)", name, got, exp, cycles);
			abort_run();
		end
	endtask

	task automatic check_seg(seg_t got, seg_t exp, string name);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h expected %h (cycle %0d)", name, got, exp, cycles);
			abort_run();
		end
	endtask

	initial begin
		int     seed_ret;
		pixel_t clear_px;
		seed_ret = $urandom(SEED);
		CLOCK_50 = 1'b0;
		arst_n = 1'b0;
		p1_cmd = '0;
		p2_cmd = '0;
		m_p1 = '{8'd144, HOME_Y, gun_col(8'd144, 1'b1), HOME_Y + GUN_DY, BULLET_READY};
		m_p2 = '{8'd8, HOME_Y, gun_col(8'd8, 1'b0), HOME_Y + GUN_DY, BULLET_READY};
		drawn_p1 = m_p1;
		drawn_p2 = m_p2;
		m_score1 = '0;
		m_score2 = '0;
		hits_seen = 0;
		drift1 = 0;
		drift2 = 0;

		repeat (2) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		check_plot(plot, 1'b0, "plot");
		check_seg(seg_p1, digit_pattern(4'h0), "seg_p1");
		check_seg(seg_p2, digit_pattern(4'h0), "seg_p2");
		@(posedge CLOCK_50);
		arst_n <= 1'b1;

		for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
			@(posedge CLOCK_50);
			if (cyc > 0 && cyc % FRAME_CYCLES == 0) begin
				update_model();
				if (cyc >= CLEAR_PIXELS && exp_q.size() == 0)
					push_frame();	// Plotter idle, so it takes this frame
			end
			if (cyc % FRAME_CYCLES == 0)
				drive_commands(cyc / FRAME_CYCLES);

			@(negedge CLOCK_50);
			if (cyc < CLEAR_PIXELS) begin
				clear_px = '{x: coord_t'(cyc % FIELD_W), y: coord_t'(cyc / FIELD_W),
					colour: COL_BLACK};
				check_plot(plot, 1'b1, "plot");
				check_pixel(pixel, clear_px, "pixel");
			end else if (exp_q.size() > 0) begin
				check_plot(plot, 1'b1, "plot");
				check_pixel(pixel, exp_q.pop_front(), "pixel");
			end else begin
				check_plot(plot, 1'b0, "plot");
			end
			if (cyc % FRAME_CYCLES == FRAME_CYCLES / 2) begin
				check_seg(seg_p1, digit_pattern(m_score1), "seg_p1");
				check_seg(seg_p2, digit_pattern(m_score2), "seg_p2");
			end
		end

		$display("Hits scored during the run: %0d", hits_seen);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- verilog.f
design/game_pkg.sv
design/pixel_pkg.sv
design/frame_tick.sv
design/player_unit.sv
design/score_keeper.sv
design/sprite_plotter.sv
design/tank_duel.sv
tb/tank_duel_properties.sv
tb/tb_tank_duel.sv
